// ==== Makefile ====
TOP = tb_checker

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
checker_pkg.sv
checker_ram.sv
checker_bus.sv
mpu_core.sv
checker_single.sv
checker_ctlif.sv
checker_top.sv
tb_checker.sv

// ==== checker_bus.sv ====
`timescale 1ns/1ns

module checker_bus (
  input  logic                    mpu_clk_i,
  input  logic                    mpu_rst_i,
  input  checker_pkg::bus_word_t  wb_adr_i,
  input  checker_pkg::bus_word_t  wb_dat_i,
  input  logic [3:0]              wb_sel_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_we_i,
  output checker_pkg::bus_word_t  wb_dat_o,
  output logic                    wb_ack_o,
  input  logic                    run_busy_i,
  input  checker_pkg::iaddr_t     fetch_addr_i,
  output checker_pkg::instr_t     fetch_data_o,
  input  checker_pkg::paddr_t     page_addr_i,
  output checker_pkg::page_word_t page_data_o
);

  logic                   page_sel;
  logic                   lane_hi;
  logic                   accept;
  logic                   region_q;
  logic                   lane_q;
  logic [31:0]            byte_mask;
  checker_pkg::instr_t    imem_mask;
  checker_pkg::page_word_t page_mask;
  checker_pkg::instr_t    imem_rd;
  checker_pkg::page_word_t page_rd;

  assign page_sel = wb_adr_i[checker_pkg::BUS_REGION_BIT];
  assign lane_hi  = wb_adr_i[2];

  // Page cache is held off while the MPU may be reading it
  assign accept = wb_stb_i & wb_cyc_i & ~wb_ack_o & ~(page_sel & run_busy_i);

  assign byte_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

  // High instruction lane carries only bits 47-32
  assign imem_mask = lane_hi ? {byte_mask[15:0], 32'b0} : {16'b0, byte_mask};
  assign page_mask = lane_hi ? {byte_mask, 32'b0} : {32'b0, byte_mask};

  always_ff @(posedge mpu_clk_i) begin
    if (mpu_rst_i) begin
      wb_ack_o <= 1'b0;
      region_q <= 1'b0;
      lane_q   <= 1'b0;
    end else begin
      wb_ack_o <= accept;
      region_q <= page_sel;
      lane_q   <= lane_hi;
    end
  end

  checker_ram #(
    .word_t (checker_pkg::instr_t),
    .DEPTH  (checker_pkg::IMEM_DEPTH)
  ) imem (
    .mpu_clk_i   (mpu_clk_i),
    .we_i        (accept & wb_we_i & ~page_sel),
    .wr_addr_i   (wb_adr_i[10:3]),
    .wr_data_i   ({wb_dat_i[15:0], wb_dat_i}),
    .wr_mask_i   (imem_mask),
    .rd_a_addr_i (fetch_addr_i),
    .rd_a_data_o (fetch_data_o),
    .rd_b_addr_i (wb_adr_i[10:3]),
    .rd_b_data_o (imem_rd)
  );

  checker_ram #(
    .word_t (checker_pkg::page_word_t),
    .DEPTH  (checker_pkg::PAGE_DEPTH)
  ) pcache (
    .mpu_clk_i   (mpu_clk_i),
    .we_i        (accept & wb_we_i & page_sel),
    .wr_addr_i   (wb_adr_i[11:3]),
    .wr_data_i   ({wb_dat_i, wb_dat_i}),
    .wr_mask_i   (page_mask),
    .rd_a_addr_i (page_addr_i),
    .rd_a_data_o (page_data_o),
    .rd_b_addr_i (wb_adr_i[11:3]),
    .rd_b_data_o (page_rd)
  );

  always_comb begin
    if (region_q) begin
      wb_dat_o = lane_q ? page_rd[63:32] : page_rd[31:0];
    end else begin
      wb_dat_o = lane_q ? {16'b0, imem_rd[47:32]} : imem_rd[31:0];
    end
  end

endmodule

// ==== checker_ctlif.sv ====
`timescale 1ns/1ns

module checker_ctlif (
  input  logic                    mpu_clk_i,
  input  logic                    mpu_rst_i,
  input  logic [13:0]             csr_a_i,
  input  logic                    csr_we_i,
  input  checker_pkg::bus_word_t  csr_di_i,
  output checker_pkg::bus_word_t  csr_do_o,
  output logic                    irq_o,
  output logic                    single_start_o,
  output checker_pkg::iaddr_t     start_addr_o,
  output logic                    run_busy_o,
  input  logic                    single_done_i,
  input  logic                    single_error_i,
  input  logic                    single_notify_i,
  input  checker_pkg::page_word_t single_data_i
);

  logic                    bank_hit;
  logic [2:0]              idx;
  logic                    wr;
  logic                    start_req;
  checker_pkg::mode_t      start_mode;
  checker_pkg::mode_t      mode_q;
  logic                    irq_en_q;
  checker_pkg::page_word_t addr_q;
  checker_pkg::page_word_t data_q;
  logic                    end_q;
  logic                    err_q;
  logic                    notified_q;
  logic                    quick_q;
  logic                    quick_err_q;

  assign bank_hit   = csr_a_i[13:10] == checker_pkg::CSR_BANK;
  assign idx        = csr_a_i[2:0];
  assign wr         = csr_we_i & bank_hit;
  assign start_mode = csr_di_i[1:0];
  assign start_req  = wr & (idx == checker_pkg::CSR_CTRL) & csr_di_i[2] & ~run_busy_o;

  assign irq_o = end_q & irq_en_q;

  // Instruction index is the low byte of the mode address
  assign start_addr_o = addr_q[7:0];

  always_ff @(posedge mpu_clk_i) begin
    if (mpu_rst_i) begin
      mode_q         <= checker_pkg::MODE_DUMMY;
      irq_en_q       <= 1'b0;
      addr_q         <= '0;
      data_q         <= '0;
      end_q          <= 1'b0;
      err_q          <= 1'b0;
      notified_q     <= 1'b0;
      run_busy_o     <= 1'b0;
      single_start_o <= 1'b0;
      quick_q        <= 1'b0;
      quick_err_q    <= 1'b0;
    end else begin
      single_start_o <= 1'b0;
      quick_q        <= 1'b0;
      if (wr) begin
        case (idx)
          checker_pkg::CSR_CTRL: begin
            mode_q   <= start_mode;
            irq_en_q <= csr_di_i[3];
          end
          checker_pkg::CSR_ADDR_LO: addr_q[31:0] <= csr_di_i;
          checker_pkg::CSR_ADDR_HI: addr_q[63:32] <= csr_di_i;
          checker_pkg::CSR_STATUS: begin
            end_q      <= 1'b0;
            err_q      <= 1'b0;
            notified_q <= 1'b0;
          end
          default: ;
        endcase
      end
      if (start_req) begin
        run_busy_o <= 1'b1;
        end_q      <= 1'b0;
        err_q      <= 1'b0;
        notified_q <= 1'b0;
        if (start_mode == checker_pkg::MODE_SINGLE) begin
          single_start_o <= 1'b1;
        end else begin
          quick_q     <= 1'b1;
          quick_err_q <= (start_mode == checker_pkg::MODE_AUTO) ||
                         (start_mode == checker_pkg::MODE_READ);
        end
      end
      // Dummy and unsupported modes finish right away
      if (quick_q) begin
        run_busy_o <= 1'b0;
        end_q      <= 1'b1;
        err_q      <= quick_err_q;
        notified_q <= 1'b0;
        if (!quick_err_q) begin
          data_q <= addr_q;
        end
      end
      if (single_done_i) begin
        run_busy_o <= 1'b0;
        end_q      <= 1'b1;
        err_q      <= single_error_i;
        notified_q <= single_notify_i;
        data_q     <= single_data_i;
      end
    end
  end

  always_ff @(posedge mpu_clk_i) begin
    if (mpu_rst_i || !bank_hit) begin
      csr_do_o <= '0;
    end else begin
      case (idx)
        checker_pkg::CSR_CTRL:    csr_do_o <= {27'b0, run_busy_o, irq_en_q, 1'b0, mode_q};
        checker_pkg::CSR_ADDR_LO: csr_do_o <= addr_q[31:0];
        checker_pkg::CSR_ADDR_HI: csr_do_o <= addr_q[63:32];
        checker_pkg::CSR_STATUS:  csr_do_o <= {29'b0, notified_q, err_q, end_q};
        checker_pkg::CSR_DATA_LO: csr_do_o <= data_q[31:0];
        checker_pkg::CSR_DATA_HI: csr_do_o <= data_q[63:32];
        default:                  csr_do_o <= '0;
      endcase
    end
  end

endmodule

// ==== checker_pkg.sv ====
package checker_pkg;

  typedef logic [31:0] bus_word_t;
  typedef logic [47:0] instr_t;
  typedef logic [63:0] page_word_t;
  typedef logic [7:0]  iaddr_t;
  typedef logic [8:0]  paddr_t;
  typedef logic [1:0]  mode_t;

  localparam int IMEM_DEPTH = 256;
  localparam int PAGE_DEPTH = 512;

  // Check modes
  localparam mode_t MODE_DUMMY  = 2'd0;
  localparam mode_t MODE_SINGLE = 2'd1;
  localparam mode_t MODE_AUTO   = 2'd2;
  localparam mode_t MODE_READ   = 2'd3;

  // Address bit 15 set selects the page cache
  localparam int BUS_REGION_BIT = 15;

  localparam logic [3:0] CSR_BANK = 4'd0;

  localparam logic [2:0] CSR_CTRL    = 3'd0;
  localparam logic [2:0] CSR_ADDR_LO = 3'd1;
  localparam logic [2:0] CSR_ADDR_HI = 3'd2;
  localparam logic [2:0] CSR_STATUS  = 3'd3;
  localparam logic [2:0] CSR_DATA_LO = 3'd4;
  localparam logic [2:0] CSR_DATA_HI = 3'd5;

  // MPU opcodes in instruction bits 47-44
  localparam logic [3:0] OP_END    = 4'd0;
  localparam logic [3:0] OP_LOAD   = 4'd1;
  localparam logic [3:0] OP_MASK   = 4'd2;
  localparam logic [3:0] OP_CMP    = 4'd3;
  localparam logic [3:0] OP_NOTIFY = 4'd4;

endpackage

// ==== checker_ram.sv ====
`timescale 1ns/1ns

module checker_ram #(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = 256
) (
  input  logic                     mpu_clk_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  word_t                    wr_data_i,
  input  word_t                    wr_mask_i,
  input  logic [$clog2(DEPTH)-1:0] rd_a_addr_i,
  output word_t                    rd_a_data_o,
  input  logic [$clog2(DEPTH)-1:0] rd_b_addr_i,
  output word_t                    rd_b_data_o
);

  word_t mem [DEPTH];

  // Only the masked bits change on a write
  always_ff @(posedge mpu_clk_i) begin
    if (we_i) begin
      mem[wr_addr_i] <= (mem[wr_addr_i] & ~wr_mask_i) | (wr_data_i & wr_mask_i);
    end
    rd_a_data_o <= mem[rd_a_addr_i];
    rd_b_data_o <= mem[rd_b_addr_i];
  end

endmodule

// ==== checker_single.sv ====
`timescale 1ns/1ns

module checker_single (
  input  logic                    mpu_clk_i,
  input  logic                    mpu_rst_i,
  input  logic                    start_i,
  input  checker_pkg::iaddr_t     start_addr_i,
  output logic                    mpu_restart_o,
  output logic                    mpu_en_o,
  output checker_pkg::iaddr_t     pc_start_o,
  input  logic                    mpu_halt_i,
  input  logic                    mpu_error_i,
  input  logic                    user_notify_i,
  input  checker_pkg::page_word_t user_data_i,
  output logic                    done_o,
  output logic                    error_o,
  output logic                    notify_o,
  output checker_pkg::page_word_t data_o
);

  // The MPU enable doubles as the running flag
  assign done_o  = mpu_en_o & (mpu_halt_i | mpu_error_i);
  assign error_o = mpu_error_i;

  always_ff @(posedge mpu_clk_i) begin
    if (mpu_rst_i) begin
      mpu_restart_o <= 1'b0;
      mpu_en_o      <= 1'b0;
      pc_start_o    <= '0;
      notify_o      <= 1'b0;
    end else begin
      mpu_restart_o <= start_i;
      if (start_i) begin
        mpu_en_o   <= 1'b1;
        pc_start_o <= start_addr_i;
        notify_o   <= 1'b0;
      end else begin
        if (done_o) begin
          mpu_en_o <= 1'b0;
        end
        if (mpu_en_o && user_notify_i) begin
          notify_o <= 1'b1;
        end
      end
    end
  end

  // Keep the latest published value
  always_ff @(posedge mpu_clk_i) begin
    if (start_i) begin
      data_o <= '0;
    end else if (mpu_en_o && user_notify_i) begin
      data_o <= user_data_i;
    end
  end

endmodule

// ==== checker_testdata.txt ====
# W adr data sel | R adr expect | C csr_index data irq_expect
# S mode irq_en addr_hi addr_lo status data_hi data_lo probe_adr probe_expect (probe_adr 0: none)
W 00000088 5aff33ff f
W 00000088 00aa00cc a
W 0000008c beef2000 f
R 00000088 00ff00ff
R 0000008c 00002000
W 00008010 c3a59617 f
W 00008014 7e7e0001 f
R 00008010 c3a59617
R 00008014 7e7e0001
W 00000084 00001010 f
W 00000094 00004000 f
W 00000098 00a50017 f
W 0000009c 00003000 f
W 000000a4 00000000 f
W 000000c4 0000f000 f
S 1 1 00000000 00000010 5 00000000 00a50017 00000000 00000000
C 3 00000000 0
S 1 0 00000000 00000013 3 00000000 00000000 00000000 00000000
S 1 0 00000000 00000018 3 00000000 00000000 00000000 00000000
S 0 0 12345678 9abcdef0 1 12345678 9abcdef0 00000000 00000000
S 2 0 00000000 00000000 3 00000000 00000000 00000000 00000000
S 3 0 00000000 00000000 3 00000000 00000000 00000000 00000000
S 1 0 00000000 00000010 5 00000000 00a50017 00008010 c3a59617

// ==== checker_top.sv ====
`timescale 1ns/1ns

module checker_top (
  input  logic                   mpu_clk_i,
  input  logic                   mpu_rst_i,
  input  checker_pkg::bus_word_t wb_adr_i,
  input  checker_pkg::bus_word_t wb_dat_i,
  input  logic [3:0]             wb_sel_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_we_i,
  output checker_pkg::bus_word_t wb_dat_o,
  output logic                   wb_ack_o,
  input  logic [13:0]            csr_a_i,
  input  logic                   csr_we_i,
  input  checker_pkg::bus_word_t csr_di_i,
  output checker_pkg::bus_word_t csr_do_o,
  output logic                   irq_o
);

  logic                    run_busy;
  logic                    single_start;
  checker_pkg::iaddr_t     start_addr;
  logic                    run_done;
  logic                    run_error;
  logic                    run_notify;
  checker_pkg::page_word_t run_data;
  logic                    mpu_restart;
  logic                    mpu_en;
  checker_pkg::iaddr_t     pc_start;
  logic                    mpu_halt;
  logic                    mpu_error;
  logic                    user_notify;
  checker_pkg::page_word_t user_data;
  checker_pkg::iaddr_t     fetch_addr;
  checker_pkg::instr_t     fetch_data;
  checker_pkg::paddr_t     page_addr;
  checker_pkg::page_word_t page_data;

  checker_ctlif ctlif (
    .mpu_clk_i       (mpu_clk_i),
    .mpu_rst_i       (mpu_rst_i),
    .csr_a_i         (csr_a_i),
    .csr_we_i        (csr_we_i),
    .csr_di_i        (csr_di_i),
    .csr_do_o        (csr_do_o),
    .irq_o           (irq_o),
    .single_start_o  (single_start),
    .start_addr_o    (start_addr),
    .run_busy_o      (run_busy),
    .single_done_i   (run_done),
    .single_error_i  (run_error),
    .single_notify_i (run_notify),
    .single_data_i   (run_data)
  );

  checker_single single (
    .mpu_clk_i     (mpu_clk_i),
    .mpu_rst_i     (mpu_rst_i),
    .start_i       (single_start),
    .start_addr_i  (start_addr),
    .mpu_restart_o (mpu_restart),
    .mpu_en_o      (mpu_en),
    .pc_start_o    (pc_start),
    .mpu_halt_i    (mpu_halt),
    .mpu_error_i   (mpu_error),
    .user_notify_i (user_notify),
    .user_data_i   (user_data),
    .done_o        (run_done),
    .error_o       (run_error),
    .notify_o      (run_notify),
    .data_o        (run_data)
  );

  mpu_core mpu (
    .mpu_clk_i     (mpu_clk_i),
    .mpu_rst_i     (mpu_rst_i),
    .en_i          (mpu_en),
    .restart_i     (mpu_restart),
    .pc_start_i    (pc_start),
    .fetch_addr_o  (fetch_addr),
    .fetch_data_i  (fetch_data),
    .page_addr_o   (page_addr),
    .page_data_i   (page_data),
    .user_notify_o (user_notify),
    .user_data_o   (user_data),
    .halt_o        (mpu_halt),
    .error_o       (mpu_error)
  );

  checker_bus bus (
    .mpu_clk_i    (mpu_clk_i),
    .mpu_rst_i    (mpu_rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_stb_i     (wb_stb_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_we_i      (wb_we_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .run_busy_i   (run_busy),
    .fetch_addr_i (fetch_addr),
    .fetch_data_o (fetch_data),
    .page_addr_i  (page_addr),
    .page_data_o  (page_data)
  );

endmodule

// ==== mpu_core.sv ====
`timescale 1ns/1ns

module mpu_core (
  input  logic                    mpu_clk_i,
  input  logic                    mpu_rst_i,
  input  logic                    en_i,
  input  logic                    restart_i,
  input  checker_pkg::iaddr_t     pc_start_i,
  output checker_pkg::iaddr_t     fetch_addr_o,
  input  checker_pkg::instr_t     fetch_data_i,
  output checker_pkg::paddr_t     page_addr_o,
  input  checker_pkg::page_word_t page_data_i,
  output logic                    user_notify_o,
  output checker_pkg::page_word_t user_data_o,
  output logic                    halt_o,
  output logic                    error_o
);

  typedef enum logic [1:0] {
    ST_STOP,
    ST_FETCH,
    ST_EXEC,
    ST_LOAD
  } state_t;

  state_t                  state_q;
  checker_pkg::iaddr_t     pc_q;
  checker_pkg::page_word_t acc_q;
  logic [3:0]              opcode;
  logic [31:0]             imm;
  logic                    exec;

  assign opcode = fetch_data_i[47:44];
  assign imm    = fetch_data_i[31:0];
  assign exec   = en_i & (state_q == ST_EXEC);

  assign fetch_addr_o = pc_q;
  // Byte offset bits 11-3 give the page word
  assign page_addr_o  = fetch_data_i[43:35];

  always_ff @(posedge mpu_clk_i) begin
    if (mpu_rst_i) begin
      state_q       <= ST_STOP;
      pc_q          <= '0;
      halt_o        <= 1'b0;
      error_o       <= 1'b0;
      user_notify_o <= 1'b0;
    end else begin
      halt_o        <= 1'b0;
      error_o       <= 1'b0;
      user_notify_o <= 1'b0;
      if (restart_i) begin
        state_q <= ST_FETCH;
        pc_q    <= pc_start_i;
      end else if (en_i) begin
        case (state_q)
          ST_FETCH: state_q <= ST_EXEC;
          ST_EXEC: begin
            state_q <= ST_FETCH;
            pc_q    <= pc_q + 1'b1;
            case (opcode)
              checker_pkg::OP_END: begin
                halt_o  <= 1'b1;
                state_q <= ST_STOP;
              end
              checker_pkg::OP_LOAD: begin
                pc_q    <= pc_q;
                state_q <= ST_LOAD;
              end
              checker_pkg::OP_MASK: ;
              checker_pkg::OP_CMP: begin
                if (acc_q[31:0] != imm) begin
                  error_o <= 1'b1;
                  state_q <= ST_STOP;
                end
              end
              checker_pkg::OP_NOTIFY: user_notify_o <= 1'b1;
              default: begin
                error_o <= 1'b1;
                state_q <= ST_STOP;
              end
            endcase
          end
          ST_LOAD: begin
            state_q <= ST_FETCH;
            pc_q    <= pc_q + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Accumulator and published data
  always_ff @(posedge mpu_clk_i) begin
    if (restart_i) begin
      acc_q <= '0;
    end else if (en_i && state_q == ST_LOAD) begin
      acc_q <= page_data_i;
    end else if (exec && opcode == checker_pkg::OP_MASK) begin
      acc_q <= {32'b0, acc_q[31:0] & imm};
    end
    if (exec && opcode == checker_pkg::OP_NOTIFY) begin
      user_data_o <= acc_q;
    end
  end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker;

  localparam int ACK_TIMEOUT = 100;
  localparam int RUN_TIMEOUT = 200;

  logic                   mpu_clk;
  logic                   mpu_rst;
  checker_pkg::bus_word_t wb_adr;
  checker_pkg::bus_word_t wb_dat_w;
  logic [3:0]             wb_sel;
  logic                   wb_stb;
  logic                   wb_cyc;
  logic                   wb_we;
  checker_pkg::bus_word_t wb_dat_r;
  logic                   wb_ack;
  logic [13:0]            csr_a;
  logic                   csr_we;
  checker_pkg::bus_word_t csr_di;
  checker_pkg::bus_word_t csr_do;
  logic                   irq;

  checker_top uut (
    .mpu_clk_i (mpu_clk),
    .mpu_rst_i (mpu_rst),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_dat_w),
    .wb_sel_i  (wb_sel),
    .wb_stb_i  (wb_stb),
    .wb_cyc_i  (wb_cyc),
    .wb_we_i   (wb_we),
    .wb_dat_o  (wb_dat_r),
    .wb_ack_o  (wb_ack),
    .csr_a_i   (csr_a),
    .csr_we_i  (csr_we),
    .csr_di_i  (csr_di),
    .csr_do_o  (csr_do),
    .irq_o     (irq)
  );

  always #4 mpu_clk = ~mpu_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_bus_word(input string name, input checker_pkg::bus_word_t got,
                                input checker_pkg::bus_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_data(input string name, input checker_pkg::page_word_t got,
                            input checker_pkg::page_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_status(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, got));
    end
  endtask

  // Always steps at least one cycle, since a previous ack may still be visible
  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(negedge mpu_clk);
      n++;
      if (n > ACK_TIMEOUT) begin
        abort_run($sformatf("Timeout: no Wishbone acknowledge for address 0x%h", wb_adr));
      end
    end while (!wb_ack);
  endtask

  task automatic bus_write(input checker_pkg::bus_word_t adr, input checker_pkg::bus_word_t dat,
                           input logic [3:0] sel);
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    wb_we    = 1'b1;
    wb_stb   = 1'b1;
    wb_cyc   = 1'b1;
    wait_ack();
    wb_stb = 1'b0;
    wb_cyc = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input checker_pkg::bus_word_t adr, output checker_pkg::bus_word_t dat);
    wb_adr = adr;
    wb_sel = 4'hf;
    wb_we  = 1'b0;
    wb_stb = 1'b1;
    wb_cyc = 1'b1;
    wait_ack();
    dat    = wb_dat_r;
    wb_stb = 1'b0;
    wb_cyc = 1'b0;
  endtask

  task automatic csr_write(input logic [2:0] idx, input checker_pkg::bus_word_t dat);
    csr_a  = {11'b0, idx};
    csr_di = dat;
    csr_we = 1'b1;
    @(negedge mpu_clk);
    csr_we = 1'b0;
  endtask

  task automatic csr_read(input logic [2:0] idx, output checker_pkg::bus_word_t dat);
    csr_a  = {11'b0, idx};
    csr_we = 1'b0;
    @(negedge mpu_clk);
    dat = csr_do;
  endtask

  task automatic wait_run_end(output logic [2:0] status);
    int n;
    n = 0;
    csr_a  = {11'b0, checker_pkg::CSR_STATUS};
    csr_we = 1'b0;
    do begin
      @(negedge mpu_clk);
      n++;
      if (n > RUN_TIMEOUT) begin
        abort_run("Timeout: the run never set the end flag");
      end
    end while (!csr_do[0]);
    status = csr_do[2:0];
  endtask

  // CTRL readback runs alongside the bus read to watch the busy bit
  task automatic probe_page_read(input checker_pkg::bus_word_t adr,
                                 input checker_pkg::bus_word_t exp);
    int   n;
    logic busy_seen;
    n         = 0;
    busy_seen = 1'b0;
    csr_a     = {11'b0, checker_pkg::CSR_CTRL};
    wb_adr    = adr;
    wb_sel    = 4'hf;
    wb_we     = 1'b0;
    wb_stb    = 1'b1;
    wb_cyc    = 1'b1;
    do begin
      @(negedge mpu_clk);
      n++;
      if (n > RUN_TIMEOUT) begin
        abort_run("Timeout: page read during the run was never acknowledged");
      end
      if (!wb_ack && csr_do[4]) begin
        busy_seen = 1'b1;
      end
    end while (!wb_ack);
    check_bus_word("csr_do_o busy at acknowledge", csr_do & 32'h10, 32'h0);
    check_bus_word("wb_dat_o", wb_dat_r, exp);
    wb_stb = 1'b0;
    wb_cyc = 1'b0;
    if (!busy_seen) begin
      abort_run("Page read was not held off while the run was busy");
    end
  endtask

  task automatic run_check(input checker_pkg::bus_word_t mode, input checker_pkg::bus_word_t irq_en,
                           input checker_pkg::bus_word_t addr_hi,
                           input checker_pkg::bus_word_t addr_lo,
                           input checker_pkg::bus_word_t status,
                           input checker_pkg::bus_word_t data_hi,
                           input checker_pkg::bus_word_t data_lo,
                           input checker_pkg::bus_word_t probe_adr,
                           input checker_pkg::bus_word_t probe_exp);
    logic [2:0]             st;
    checker_pkg::bus_word_t lo;
    checker_pkg::bus_word_t hi;
    csr_write(checker_pkg::CSR_ADDR_LO, addr_lo);
    csr_write(checker_pkg::CSR_ADDR_HI, addr_hi);
    csr_write(checker_pkg::CSR_CTRL, {28'b0, irq_en[0], 1'b1, mode[1:0]});
    if (probe_adr != 32'h0) begin
      probe_page_read(probe_adr, probe_exp);
    end
    wait_run_end(st);
    check_status("status", st, status[2:0]);
    // Result data has no defined value after an error
    if (!status[1]) begin
      csr_read(checker_pkg::CSR_DATA_LO, lo);
      csr_read(checker_pkg::CSR_DATA_HI, hi);
      check_data("result data", {hi, lo}, {data_hi, data_lo});
    end
    check_bus_word("irq_o", {31'b0, irq}, {31'b0, irq_en[0]});
  endtask

  initial begin
    int                     fd;
    int                     ch;
    int                     n;
    int                     cmd_count;
    byte                    c;
    checker_pkg::bus_word_t f [9];
    checker_pkg::bus_word_t rd;
    mpu_clk   = 1'b0;
    mpu_rst   = 1'b1;
    wb_adr    = '0;
    wb_dat_w  = '0;
    wb_sel    = 4'h0;
    wb_stb    = 1'b0;
    wb_cyc    = 1'b0;
    wb_we     = 1'b0;
    csr_a     = '0;
    csr_we    = 1'b0;
    csr_di    = '0;
    cmd_count = 0;
    repeat (3) @(negedge mpu_clk);
    mpu_rst = 1'b0;
    fd = $fopen("checker_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open checker_testdata.txt");
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      c = byte'(ch);
      if (c == "#") begin
        while (ch != -1 && c != "\n") begin
          ch = $fgetc(fd);
          c  = byte'(ch);
        end
      end else if (c == "W") begin
        n = $fscanf(fd, " %h %h %h", f[0], f[1], f[2]);
        if (n != 3) begin
          abort_run("Malformed W line in the test data");
        end
        bus_write(f[0], f[1], f[2][3:0]);
        cmd_count++;
      end else if (c == "R") begin
        n = $fscanf(fd, " %h %h", f[0], f[1]);
        if (n != 2) begin
          abort_run("Malformed R line in the test data");
        end
        bus_read(f[0], rd);
        check_bus_word("wb_dat_o", rd, f[1]);
        cmd_count++;
      end else if (c == "C") begin
        n = $fscanf(fd, " %h %h %h", f[0], f[1], f[2]);
        if (n != 3) begin
          abort_run("Malformed C line in the test data");
        end
        csr_write(f[0][2:0], f[1]);
        check_bus_word("irq_o", {31'b0, irq}, {31'b0, f[2][0]});
        cmd_count++;
      end else if (c == "S") begin
        n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (n != 9) begin
          abort_run("Malformed S line in the test data");
        end
        run_check(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        cmd_count++;
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        abort_run($sformatf("Unknown command '%c' in the test data", c));
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
    if (cmd_count == 0) begin
      abort_run("The test data held no commands");
    end
    $display("Done: no errors");
    $finish;
  end

endmodule
